// ==== common/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// operand and result width
`define EXEC_XLEN 32

// request tag width
`define EXEC_TAG_W 4

// consumer buffer depth, initial credit count
`define EXEC_CREDITS 4

// one restoring step per result bit
`define EXEC_DIV_STEPS `EXEC_XLEN

`endif

// ==== common/aluOpsPkg.sv ====
package aluOpsPkg;

  typedef enum logic [5:0] {
    opAnd    = 6'b000000,
    opOr     = 6'b000001,
    opAdd    = 6'b000010,
    opSll    = 6'b000011,
    opSrl    = 6'b000100,
    opXor    = 6'b000101,
    opSub    = 6'b000110,
    opSra    = 6'b000111,
    opBeq    = 6'b001000, // branch compares return 0 when taken
    opBne    = 6'b001001,
    opBlt    = 6'b001010,
    opBge    = 6'b001011,
    opBltu   = 6'b001100,
    opBgeu   = 6'b001101,
    opMul    = 6'b010000,
    opMulh   = 6'b010001,
    opMulhsu = 6'b010010,
    opMulhu  = 6'b010011,
    opDiv    = 6'b010100,
    opDivu   = 6'b010101,
    opRem    = 6'b010110,
    opRemu   = 6'b010111,
    opMin    = 6'b100000,
    opMax    = 6'b100001,
    opMinu   = 6'b100010,
    opMaxu   = 6'b100011,
    opSlt    = 6'b100101,
    opSltu   = 6'b100110
  } aluOp_e;

  // branch compares share the basic group, func[3] set
  typedef enum logic [1:0] {
    grpBasic  = 2'b00,
    grpMulDiv = 2'b01,
    grpMinMax = 2'b10, // also slt/sltu
    grpRsvd   = 2'b11
  } opGroup_e;

  typedef struct packed {
    opGroup_e   group;
    logic [3:0] func; // muldiv: [2] divide, [1] remainder, [0] unsigned
  } opFields_t;

  typedef union packed {
    aluOp_e    code;
    opFields_t fields;
  } aluOpWord_u;

endpackage

// ==== common/execPkg.sv ====
`include "exec_params.svh"

package execPkg;
  import aluOpsPkg::*;

  typedef struct packed {
    aluOpWord_u            op;
    logic [`EXEC_XLEN-1:0]  operand1;
    logic [`EXEC_XLEN-1:0]  operand2;
    logic [`EXEC_TAG_W-1:0] tag;
  } execReq_t;

  // engine to merge stage
  typedef struct packed {
    logic                   valid;
    logic [`EXEC_XLEN-1:0]  value;
    logic [`EXEC_TAG_W-1:0] tag;
  } engineResult_t;

  // output word to the consumer
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]  value;
    logic                   zero;
    logic [`EXEC_TAG_W-1:0] tag;
  } execResult_t;

endpackage

// ==== src/issueCtrl.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module issueCtrl import execPkg::*; import aluOpsPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     reqValid,
  input  execReq_t req,
  output logic     issueReady,
  input  logic     resCredit,
  input  logic     divBusy,
  output logic     aluStart,
  output logic     divStart,
  output execReq_t engineReq
);

  localparam int CREDIT_W = $clog2(`EXEC_CREDITS + 1);

  logic [CREDIT_W-1:0] credits;
  logic                hasCredit;
  logic                isDiv;
  logic                accept;

  // divide is muldiv group with func[2] set
  assign isDiv = (req.op.fields.group == grpMulDiv) && req.op.fields.func[2];

  assign hasCredit  = (credits != '0);
  assign issueReady = hasCredit && !(divBusy && isDiv); // ALU ops may pass a running divide
  assign accept     = reqValid && issueReady;

  assign aluStart  = accept && !isDiv;
  assign divStart  = accept && isDiv;
  assign engineReq = req;

  // one credit reserved per accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`EXEC_CREDITS);
    end else begin
      case ({accept, resCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // none, or both cancel
      endcase
    end
  end

endmodule

// ==== alu/intAlu.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module intAlu import execPkg::*; import aluOpsPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  execReq_t      req,
  output engineResult_t result
);

  localparam int XLEN = `EXEC_XLEN;

  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  logic [4:0]        shamt;
  logic              eq;
  logic              lt;
  logic              ltu;
  logic [2*XLEN-1:0] prodSS;
  logic [2*XLEN-1:0] prodSU;
  logic [2*XLEN-1:0] prodUU;
  logic [XLEN-1:0]   aluValue;

  assign op1   = req.operand1;
  assign op2   = req.operand2;
  assign shamt = op2[4:0];

  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  // low 2*XLEN bits of the extended products
  assign prodSS = {{XLEN{op1[XLEN-1]}}, op1} * {{XLEN{op2[XLEN-1]}}, op2};
  assign prodSU = {{XLEN{op1[XLEN-1]}}, op1} * {{XLEN{1'b0}}, op2};
  assign prodUU = {{XLEN{1'b0}}, op1} * {{XLEN{1'b0}}, op2};

  always_comb begin
    case (req.op.code)
      opAdd:    aluValue = op1 + op2;
      opSub:    aluValue = op1 - op2;
      opAnd:    aluValue = op1 & op2;
      opOr:     aluValue = op1 | op2;
      opXor:    aluValue = op1 ^ op2;
      opSll:    aluValue = op1 << shamt;
      opSrl:    aluValue = op1 >> shamt;
      opSra:    aluValue = $signed(op1) >>> shamt;

      // taken gives 0
      opBeq:    aluValue = XLEN'(!eq);
      opBne:    aluValue = XLEN'(eq);
      opBlt:    aluValue = XLEN'(!lt);
      opBge:    aluValue = XLEN'(lt);
      opBltu:   aluValue = XLEN'(!ltu);
      opBgeu:   aluValue = XLEN'(ltu);

      opMul:    aluValue = prodSS[XLEN-1:0];
      opMulh:   aluValue = prodSS[2*XLEN-1:XLEN];
      opMulhsu: aluValue = prodSU[2*XLEN-1:XLEN];
      opMulhu:  aluValue = prodUU[2*XLEN-1:XLEN];

      opMin:    aluValue = lt ? op1 : op2;
      opMax:    aluValue = lt ? op2 : op1;
      opMinu:   aluValue = ltu ? op1 : op2;
      opMaxu:   aluValue = ltu ? op2 : op1;
      opSlt:    aluValue = XLEN'(lt);
      opSltu:   aluValue = XLEN'(ltu);

      default:  aluValue = op2; // divides never start here
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      result.value <= aluValue;
      result.tag   <= req.tag;
    end
  end

endmodule

// ==== divider/seqDivider.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module seqDivider import execPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  execReq_t      req,
  output logic          busy,
  output engineResult_t result
);

  localparam int XLEN  = `EXEC_XLEN;
  localparam int STEPS = `EXEC_DIV_STEPS;
  localparam int CNT_W = $clog2(STEPS);

  logic [CNT_W-1:0]       stepCount;
  logic [XLEN-1:0]        quo;
  logic [XLEN-1:0]        rem;
  logic [XLEN-1:0]        dvsr;
  logic [XLEN-1:0]        dividend;
  logic [`EXEC_TAG_W-1:0] tag;
  logic                   negQuo;
  logic                   negRem;
  logic                   wantRem;
  logic                   divZero;
  logic                   overflow;

  logic                   isSigned;
  logic                   dividendNeg;
  logic                   divisorNeg;
  logic [XLEN:0]          shifted;
  logic                   fits;
  logic [XLEN-1:0]        nextQuo;
  logic [XLEN-1:0]        nextRem;
  logic [XLEN-1:0]        finalValue;
  logic                   lastStep;

  assign isSigned    = !req.op.fields.func[0];
  assign dividendNeg = isSigned && req.operand1[XLEN-1];
  assign divisorNeg  = isSigned && req.operand2[XLEN-1];

  // one restoring step
  assign shifted = {rem, quo[XLEN-1]};
  assign fits    = (shifted >= {1'b0, dvsr});
  assign nextRem = fits ? XLEN'(shifted - {1'b0, dvsr}) : shifted[XLEN-1:0];
  assign nextQuo = {quo[XLEN-2:0], fits};

  assign lastStep = busy && (stepCount == CNT_W'(STEPS - 1));

  always_comb begin
    if (divZero) begin
      finalValue = wantRem ? dividend : '1;
    end else if (overflow) begin
      finalValue = wantRem ? '0 : dividend;
    end else if (wantRem) begin
      finalValue = negRem ? -nextRem : nextRem; // remainder takes dividend sign
    end else begin
      finalValue = negQuo ? -nextQuo : nextQuo;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      stepCount    <= '0;
      result.valid <= 1'b0;
    end else begin
      result.valid <= lastStep;
      if (start) begin
        busy      <= 1'b1;
        stepCount <= '0;
      end else if (busy) begin
        stepCount <= stepCount + 1'b1;
        if (lastStep) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo      <= dividendNeg ? -req.operand1 : req.operand1; // magnitudes
      dvsr     <= divisorNeg ? -req.operand2 : req.operand2;
      rem      <= '0;
      dividend <= req.operand1;
      tag      <= req.tag;
      negQuo   <= dividendNeg ^ divisorNeg;
      negRem   <= dividendNeg;
      wantRem  <= req.op.fields.func[1];
      divZero  <= (req.operand2 == '0);
      overflow <= isSigned && (req.operand1 == {1'b1, {(XLEN-1){1'b0}}})
                  && (req.operand2 == '1);
    end else if (busy) begin
      quo <= nextQuo;
      rem <= nextRem;
    end
    if (lastStep) begin
      result.value <= finalValue;
      result.tag   <= tag;
    end
  end

endmodule

// ==== src/resultMerge.sv ====
`timescale 1ns/100ps

module resultMerge import execPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  engineResult_t aluResult,
  input  engineResult_t divResult,
  output logic          resValid,
  output execResult_t   res
);

  engineResult_t heldDiv;
  engineResult_t pick;
  logic          holdLoad;
  logic          holdKeep;

  // ALU first, then a held divide, then a fresh divide
  always_comb begin
    if (aluResult.valid) begin
      pick = aluResult;
    end else if (heldDiv.valid) begin
      pick = heldDiv;
    end else begin
      pick = divResult;
    end
  end

  assign holdLoad = divResult.valid && (aluResult.valid || heldDiv.valid);
  assign holdKeep = heldDiv.valid && aluResult.valid && !divResult.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid      <= 1'b0;
      heldDiv.valid <= 1'b0;
    end else begin
      resValid      <= pick.valid;
      heldDiv.valid <= holdLoad || holdKeep;
    end
  end

  always_ff @(posedge clk) begin
    if (pick.valid) begin
      res.value <= pick.value;
      res.zero  <= (pick.value == '0);
      res.tag   <= pick.tag;
    end
    if (holdLoad) begin
      heldDiv.value <= divResult.value;
      heldDiv.tag   <= divResult.tag;
    end
  end

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/100ps

module execUnit import execPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        reqValid,
  input  execReq_t    req,
  output logic        issueReady,
  output logic        resValid,
  output execResult_t res,
  input  logic        resCredit
);

  logic          aluStart;
  logic          divStart;
  logic          divBusy;
  execReq_t      engineReq;
  engineResult_t aluResult;
  engineResult_t divResult;

  issueCtrl issueCtrl_i (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .issueReady (issueReady),
    .resCredit  (resCredit),
    .divBusy    (divBusy),
    .aluStart   (aluStart),
    .divStart   (divStart),
    .engineReq  (engineReq)
  );

  intAlu intAlu_i (
    .clk    (clk),
    .reset  (reset),
    .start  (aluStart),
    .req    (engineReq),
    .result (aluResult)
  );

  seqDivider seqDivider_i (
    .clk    (clk),
    .reset  (reset),
    .start  (divStart),
    .req    (engineReq),
    .busy   (divBusy),
    .result (divResult)
  );

  resultMerge resultMerge_i (
    .clk       (clk),
    .reset     (reset),
    .aluResult (aluResult),
    .divResult (divResult),
    .resValid  (resValid),
    .res       (res)
  );

endmodule

// ==== tests/execUnit_tb.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module execUnit_tb import execPkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 38;
  localparam int NUM_TAGS   = 1 << `EXEC_TAG_W;

  logic        clk;
  logic        reset;
  logic        reqValid;
  execReq_t    req;
  logic        issueReady;
  logic        resValid;
  execResult_t res;
  logic        resCredit;

  logic [31:0] vectors [0:4*NUM_TESTS-1]; // op, operand1, operand2, expected
  execResult_t expTable [NUM_TAGS];
  logic        pending [NUM_TAGS];
  int          testOf [NUM_TAGS];
  int          acceptCycle [NUM_TAGS];
  execResult_t buffer [$]; // consumer's output buffer
  integer      seed;
  int          cycleCount;
  int          errorCount;
  int          passCount;
  int          resultsSeen;
  int          issuedCount;
  int          returnedCount;

  execUnit dut_i (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .issueReady (issueReady),
    .resValid   (resValid),
    .res        (res),
    .resCredit  (resCredit)
  );

  task automatic compareResult(input execResult_t got, input execResult_t exp, output int bad);
    bad = 0;
    if (got.value !== exp.value) begin
      $display("Error: res.value expected %h got %h", exp.value, got.value);
      bad++;
    end
    if (got.zero !== exp.zero) begin
      $display("Error: res.zero expected %h got %h", exp.zero, got.zero);
      bad++;
    end
    if (got.tag !== exp.tag) begin
      $display("Error: res.tag expected %h got %h", exp.tag, got.tag);
      bad++;
    end
  endtask

  // held is the number of credits the DUT has given out
  task automatic compareCredit(input int held, input logic ready);
    if (held > `EXEC_CREDITS) begin
      $display("More results outstanding (%0d) than credits exist", held);
      errorCount++;
    end else if (held == `EXEC_CREDITS && ready) begin
      $display("issueReady is high although no credit is left");
      errorCount++;
    end
  endtask

  // ALU ops are due two cycles after issue and go first, divides after their steps plus two
  task automatic findDueTag(output logic [`EXEC_TAG_W-1:0] dueTag, output logic found);
    int         age;
    logic       isDivOp;
    logic       aluDue;
    logic       divDue;
    logic [5:0] op;
    aluDue = 1'b0;
    divDue = 1'b0;
    dueTag = '0;
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (pending[i]) begin
        op      = vectors[4*testOf[i]][5:0];
        isDivOp = (op[5:4] == 2'b01) && op[2]; // muldiv group, divide bit
        age     = cycleCount - acceptCycle[i];
        if (!isDivOp && age == 2) begin
          aluDue = 1'b1;
          dueTag = `EXEC_TAG_W'(i);
        end else if (isDivOp && age >= `EXEC_DIV_STEPS + 2 && !aluDue) begin
          divDue = 1'b1;
          dueTag = `EXEC_TAG_W'(i);
        end
      end
    end
    found = aluDue || divDue;
  endtask

  task automatic checkResult(input execResult_t got);
    int                     bad;
    execResult_t            exp;
    logic [`EXEC_TAG_W-1:0] dueTag;
    logic                   found;
    if (!pending[got.tag]) begin
      $display("A result arrived for tag %h, which has no request pending", got.tag);
      errorCount++;
    end else begin
      findDueTag(dueTag, found);
      exp     = expTable[got.tag];
      exp.tag = dueTag;
      bad     = 0;
      if (found) begin
        compareResult(got, exp, bad);
      end else begin
        $display("A result for tag %h arrived when no request was due", got.tag);
        bad = 1;
      end
      errorCount += bad;
      if (bad == 0) begin
        passCount++;
      end
      $display("Test %0d (op %h, tag %h): %s", testOf[got.tag],
               vectors[4*testOf[got.tag]][5:0], got.tag, (bad == 0) ? "ok" : "mismatch");
      pending[got.tag] = 1'b0;
    end
    resultsSeen++;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  initial begin
    #(CLK_PERIOD * (10 + NUM_TESTS * (`EXEC_DIV_STEPS + 10)));
    $display("Timeout: only %0d of %0d results came back", resultsSeen, NUM_TESTS);
    $display("*** FAILED ***");
    $finish;
  end

  // consumer pops one entry after a random delay and returns its credit
  initial begin : consumer
    int waitCycles;
    waitCycles = 0;
    forever begin
      @(negedge clk);
      resCredit = 1'b0;
      if (!reset) begin
        if (resValid) begin
          buffer.push_back(res);
          checkResult(res);
        end
        if (buffer.size() > `EXEC_CREDITS) begin
          $display("Consumer buffer overflowed with %0d entries", buffer.size());
          errorCount++;
        end
        if (buffer.size() > 0) begin
          if (waitCycles == 0) begin
            buffer.delete(0);
            resCredit = 1'b1;
            returnedCount++;
            waitCycles = $unsigned($random(seed)) % 6;
          end else begin
            waitCycles--;
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic     accepted;
    execReq_t nextReq;
    seed = 32'he0af;
    reset = 1'b1;
    reqValid = 1'b0;
    req = '0;
    resCredit = 1'b0;
    cycleCount = 0;
    errorCount = 0;
    passCount = 0;
    resultsSeen = 0;
    issuedCount = 0;
    returnedCount = 0;
    for (int i = 0; i < NUM_TAGS; i++) begin
      pending[i] = 1'b0;
    end
    $readmemh("tests/exec_tests.hex", vectors);
    if (vectors[4*NUM_TESTS-1] === 'x) begin
      $display("Test file is missing or holds fewer than %0d vectors", NUM_TESTS);
      errorCount++;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      nextReq.op       = vectors[4*t][5:0];
      nextReq.operand1 = vectors[4*t+1];
      nextReq.operand2 = vectors[4*t+2];
      nextReq.tag      = `EXEC_TAG_W'(t); // wraps modulo 16
      if (pending[nextReq.tag]) begin
        $display("Tag %h reused while its result is still pending", nextReq.tag);
        errorCount++;
      end
      expTable[nextReq.tag].value = vectors[4*t+3];
      expTable[nextReq.tag].zero  = (vectors[4*t+3] == '0);
      expTable[nextReq.tag].tag   = nextReq.tag;
      testOf[nextReq.tag] = t;
      accepted = 1'b0;
      while (!accepted) begin
        req = nextReq; // held until accepted
        reqValid = 1'b1;
        #1;
        accepted = issueReady;
        compareCredit(issuedCount - returnedCount + resCredit, issueReady);
        if (accepted) begin
          acceptCycle[nextReq.tag] = cycleCount;
          pending[nextReq.tag]     = 1'b1;
        end
        @(posedge clk);
        if (accepted) begin
          issuedCount++;
        end
        @(negedge clk);
      end
      reqValid = 1'b0;
    end
    wait (resultsSeen >= NUM_TESTS);
    repeat (5) @(negedge clk);
    $display("%0d tests, %0d passed, %0d results seen, %0d errors",
             NUM_TESTS, passCount, resultsSeen, errorCount);
    if (errorCount == 0 && passCount == NUM_TESTS && resultsSeen == NUM_TESTS) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tests/exec_tests.hex ====
// columns: op code, operand1, operand2, expected result (all hex)
// branch compares give 0 when taken
02 00000005 00000003 00000008
06 00000005 00000005 00000000
00 f0f0f0f0 ff00ff00 f000f000
01 f0f0f0f0 0f0f0f0f ffffffff
05 aaaaaaaa ffffffff 55555555
03 00000001 0000001f 80000000
04 80000000 00000004 08000000
07 80000000 00000004 f8000000
08 00000007 00000007 00000000
09 00000007 00000007 00000001
0a ffffffff 00000001 00000000
0b ffffffff 00000001 00000001
0c ffffffff 00000001 00000001
0d ffffffff 00000001 00000000
25 ffffffff 00000001 00000001
26 ffffffff 00000001 00000000
20 ffffffff 00000001 ffffffff
21 ffffffff 00000001 00000001
22 ffffffff 00000001 00000001
23 ffffffff 00000001 ffffffff
10 00012345 00001000 12345000
11 ffffffff ffffffff 00000000
11 80000000 80000000 40000000
12 ffffffff ffffffff ffffffff
13 ffffffff ffffffff fffffffe
14 00000014 fffffffa fffffffd
02 00000001 00000002 00000003
05 0000ff00 00000f0f 0000f00f
16 00000014 fffffffa 00000002
15 00000014 00000006 00000003
17 ffffffff 00000010 0000000f
16 ffffffec 00000006 fffffffe
14 00000007 00000000 ffffffff
16 00000007 00000000 00000007
14 80000000 ffffffff 80000000
16 80000000 ffffffff 00000000
15 00000007 00000000 ffffffff
05 12345678 12345678 00000000

// ==== sim.f ====
+incdir+common
common/aluOpsPkg.sv
common/execPkg.sv
src/issueCtrl.sv
alu/intAlu.sv
divider/seqDivider.sv
src/resultMerge.sv
src/execUnit.sv
tests/execUnit_tb.sv
